// File: list.f
logic/tape_pkg.sv
logic/tape_key_decode.sv
logic/tape_transport_ctrl.sv
logic/tape_addr_seq.sv
logic/tape_ce_gen.sv
logic/tape_led_pwm.sv
logic/tape_deck_top.sv
verif/tb_tape_deck.sv

// File: logic/tape_addr_seq.sv
`timescale 1ns/1ps

module tape_addr_seq #(
	parameter int ADDR_W = 25
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 restart_i,
	input  logic                 req_i,
	input  tape_pkg::tzx_event_t evt_i,
	input  logic                 download_i,
	input  logic [ADDR_W-1:0]    dl_addr_i,
	output logic [ADDR_W-1:0]    addr_o,
	output logic                 ack_o,
	output logic                 end_of_tape_o
);

	logic [ADDR_W-1:0] next_addr;
	logic [ADDR_W-1:0] tape_len;
	logic [ADDR_W-1:0] loop_addr;
	logic              download_q;
	logic              req_new;

	// Acknowledge is just the request seen one cycle late
	always_ff @(posedge clk_sys) begin
		ack_o <= req_i;
	end

	assign req_new = req_i ^ ack_o;

	// Marked address for loop blocks
	always_ff @(posedge clk_sys) begin
		if (evt_i.loop_start) begin
			loop_addr <= next_addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			next_addr     <= '0;
			addr_o        <= '0;
			tape_len      <= '0;
			download_q    <= 1'b0;
			end_of_tape_o <= 1'b0;
		end else begin
			end_of_tape_o <= 1'b0;
			download_q    <= download_i;

			// Last download address is the tape length
			if (download_q && !download_i) begin
				tape_len <= dl_addr_i;
			end

			if (restart_i) begin
				next_addr <= '0;
				addr_o    <= '0;
			end else if (req_new) begin
				addr_o    <= next_addr;
				next_addr <= next_addr + 1'b1;
				if (next_addr >= tape_len) begin
					end_of_tape_o <= 1'b1;
				end
			end

			// Jump back to the mark, fetch it now and continue after it
			if (evt_i.loop_next) begin
				addr_o    <= loop_addr;
				next_addr <= loop_addr + 1'b1;
			end
		end
	end

endmodule

// File: logic/tape_ce_gen.sv
`timescale 1ns/1ps

module tape_ce_gen (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  tape_pkg::cpu_speed_t speed_i,
	input  logic                 mem_wait_i,
	output logic                 ce_o
);

	import tape_pkg::*;

	logic [4:0] div;
	cpu_speed_t speed_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div     <= '0;
			speed_q <= SPEED_3M5;
			ce_o    <= 1'b0;
		end else begin
			div <= div + 1'b1;
			// Speed only changes at the end of a full divider period
			if (&div) begin
				speed_q <= speed_i;
			end
			case (speed_q)
				SPEED_3M5: ce_o <= (div == 5'd0);
				SPEED_7M:  ce_o <= (div[3:0] == 4'd0);
				// Fast speeds stall with the CPU on memory wait
				SPEED_14M: ce_o <= (div[2:0] == 3'd0) & ~mem_wait_i;
				SPEED_28M: ce_o <= (div[1:0] == 2'd0) & ~mem_wait_i;
				default:   ce_o <= 1'b0;
			endcase
		end
	end

endmodule

// File: logic/tape_deck_top.sv
`timescale 1ns/1ps

module tape_deck_top #(
	parameter int ADDR_W   = tape_pkg::TAPE_ADDR_W,
	parameter int LED_BITS = 23
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  tape_pkg::ps2_key_t   ps2_key_i,
	input  logic                 download_i,
	input  logic [ADDR_W-1:0]    dl_addr_i,
	input  logic                 tzx_req_i,
	input  tape_pkg::tzx_event_t tzx_evt_i,
	input  tape_pkg::cpu_speed_t cpu_speed_i,
	input  logic                 mem_wait_i,
	output logic [ADDR_W-1:0]    tape_addr_o,
	output logic                 tzx_ack_o,
	output logic                 player_restart_o,
	output logic                 motor_o,
	output logic                 tape_ready_o,
	output logic                 tape_ce_o,
	output logic                 led_o
);

	import tape_pkg::*;

	key_cmd_t key_cmd;
	logic     restart;
	logic     paused;
	logic     end_of_tape;

	// ========================================
	// Control path
	// ========================================

	tape_key_decode u_key_decode (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.key_i   (ps2_key_i),
		.cmd_o   (key_cmd)
	);

	tape_transport_ctrl u_transport (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cmd_i         (key_cmd),
		.evt_i         (tzx_evt_i),
		.download_i    (download_i),
		.end_of_tape_i (end_of_tape),
		.restart_o     (restart),
		.ready_o       (tape_ready_o),
		.paused_o      (paused)
	);

	// ========================================
	// Player side
	// ========================================

	tape_addr_seq #(
		.ADDR_W (ADDR_W)
	) u_addr_seq (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.restart_i     (restart),
		.req_i         (tzx_req_i),
		.evt_i         (tzx_evt_i),
		.download_i    (download_i),
		.dl_addr_i     (dl_addr_i),
		.addr_o        (tape_addr_o),
		.ack_o         (tzx_ack_o),
		.end_of_tape_o (end_of_tape)
	);

	tape_ce_gen u_ce_gen (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.speed_i    (cpu_speed_i),
		.mem_wait_i (mem_wait_i),
		.ce_o       (tape_ce_o)
	);

	tape_led_pwm #(
		.LED_BITS (LED_BITS)
	) u_led_pwm (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.paused_i (paused),
		.ready_i  (tape_ready_o),
		.led_o    (led_o)
	);

	// Player rewinds while restarting or with no tape loaded
	assign player_restart_o = restart | ~tape_ready_o;
	assign motor_o          = ~paused;

endmodule

// File: logic/tape_key_decode.sv
`timescale 1ns/1ps

module tape_key_decode (
	input  logic               clk_sys,
	input  logic               RESET,
	input  tape_pkg::ps2_key_t key_i,
	output tape_pkg::key_cmd_t cmd_o
);

	import tape_pkg::*;

	ps2_key_t key_q;
	logic     stb_q;
	logic     key_new;

	// Two flops on the strobe, the code travels with the first one
	always_ff @(posedge clk_sys) begin
		key_q <= key_i;
		stb_q <= key_q.strobe;
		// Load both stages alike in reset so no false event follows
		if (RESET) begin
			stb_q <= key_i.strobe;
		end
	end

	assign key_new = key_q.strobe ^ stb_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cmd_o <= '0;
		end else begin
			cmd_o <= '0;
			if (key_new) begin
				// Play/pause only on press, not on release
				if (key_q.code == KEY_F5 && key_q.pressed) begin
					cmd_o.toggle_play <= 1'b1;
				end
				if (key_q.code == KEY_F6) begin
					cmd_o.restart <= 1'b1;
				end
				if (key_q.code == KEY_F7) begin
					cmd_o.eject <= 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/tape_led_pwm.sv
`timescale 1ns/1ps

module tape_led_pwm #(
	parameter int LED_BITS = 23
) (
	input  logic clk_sys,
	input  logic RESET,
	input  logic paused_i,
	input  logic ready_i,
	output logic led_o
);

	localparam int SLICE_W = 8;

	logic [LED_BITS-1:0] act_cnt;
	logic                cnt_run;
	logic [SLICE_W-1:0]  level;
	logic [SLICE_W-1:0]  phase;

	// While stopped the counter parks where top bit and ready disagree
	assign cnt_run = ~paused_i | (act_cnt[LED_BITS-1] == ready_i) | (|act_cnt[LED_BITS-2:0]);

	assign level = act_cnt[LED_BITS-2 -: SLICE_W];
	assign phase = act_cnt[SLICE_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			act_cnt <= '0;
			led_o   <= 1'b0;
		end else begin
			if (cnt_run) begin
				act_cnt <= act_cnt + 1'b1;
			end
			// Duty ramps down in the first half, up in the second
			led_o <= act_cnt[LED_BITS-1] ? (level > phase) : (level <= phase);
		end
	end

endmodule

// File: logic/tape_pkg.sv
package tape_pkg;

	// ========================================
	// Widths and key codes
	// ========================================

	// Tape byte address and tape length
	parameter int TAPE_ADDR_W = 25;

	// PS/2 scan codes, bit 8 is the extended flag
	localparam logic [8:0] KEY_F5 = 9'h003;
	localparam logic [8:0] KEY_F6 = 9'h00B;
	localparam logic [8:0] KEY_F7 = 9'h083;

	// ========================================
	// Types
	// ========================================

	// Key event from the PS/2 host, new event on every strobe change
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	typedef enum logic [1:0] {
		SPEED_3M5 = 2'd0,
		SPEED_7M  = 2'd1,
		SPEED_14M = 2'd2,
		SPEED_28M = 2'd3
	} cpu_speed_t;

	// One-cycle command pulses from the keyboard
	typedef struct packed {
		logic toggle_play;
		logic restart;
		logic eject;
	} key_cmd_t;

	// One-cycle event pulses from the TZX player
	typedef struct packed {
		logic stop;
		logic stop48k;
		logic loop_start;
		logic loop_next;
	} tzx_event_t;

endpackage

// File: logic/tape_transport_ctrl.sv
`timescale 1ns/1ps

module tape_transport_ctrl (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  tape_pkg::key_cmd_t   cmd_i,
	input  tape_pkg::tzx_event_t evt_i,
	input  logic                 download_i,
	input  logic                 end_of_tape_i,
	output logic                 restart_o,
	output logic                 ready_o,
	output logic                 paused_o
);

	logic download_q;
	logic download_fall;
	logic restart_set;
	logic unload;

	assign download_fall = download_q & ~download_i;

	// Held for the whole download, single pulse from F6
	assign restart_set = download_i | cmd_i.restart;

	// Eject or running off the end unloads the tape
	assign unload = cmd_i.eject | end_of_tape_i;

	// ========================================
	// Transport state
	// ========================================

	// Statements further down override the ones above them
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_q <= 1'b0;
			restart_o  <= 1'b0;
			ready_o    <= 1'b0;
			paused_o   <= 1'b1;
		end else begin
			download_q <= download_i;

			restart_o <= restart_set;

			if (cmd_i.toggle_play) begin
				paused_o <= ~paused_o;
			end

			if (unload) begin
				ready_o <= 1'b0;
			end

			// No tape, or the tape goes away in this cycle
			if (!ready_o || unload) begin
				paused_o <= 1'b1;
			end

			if (restart_set) begin
				paused_o <= 1'b1;
			end

			// Player asks for a stop, also the 48k-only variant
			if (evt_i.stop || evt_i.stop48k) begin
				paused_o <= 1'b1;
			end

			// New tape in memory, start playing right away
			if (download_fall) begin
				ready_o  <= 1'b1;
				paused_o <= 1'b0;
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_tape_deck -f list.f \
	&& ./obj_dir/Vtb_tape_deck | tee /dev/stderr | grep -q "Simulation completed successfully" \
	|| { echo "Run FAILED"; exit 1; }

// File: verif/tb_tape_deck.sv
`timescale 1ns/1ps

module tb_tape_deck;

	import tape_pkg::*;

	localparam int ADDR_W   = TAPE_ADDR_W;
	localparam int LED_BITS = 12;

	// Player event pulses, field order stop, stop48k, loop_start, loop_next
	localparam tzx_event_t EV_STOP = 4'b1000;
	localparam tzx_event_t EV_LOOP = 4'b0010;
	localparam tzx_event_t EV_NEXT = 4'b0001;

	logic              clk_sys, RESET, download_i, tzx_req_i, mem_wait_i;
	logic              tzx_ack_o, player_restart_o, motor_o, tape_ready_o, tape_ce_o, led_o;
	logic [ADDR_W-1:0] dl_addr_i, tape_addr_o;
	ps2_key_t          ps2_key_i;
	tzx_event_t        tzx_evt_i;
	cpu_speed_t        cpu_speed_i;

	// Player model, request numbers count from the last restart
	int   issued  = 0;
	int   seen    = 0;
	int   loop_at = -1;
	int   mark    = 0;
	int   len;
	int   s;
	logic ack_seen = 1'b0;

	tape_deck_top #(.ADDR_W(ADDR_W), .LED_BITS(LED_BITS)) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Counter runs up from the restart point, loop_next jumps to one past the mark
	function automatic int ref_addr(input int n, input int loop_n, input int mark_addr);
		if (loop_n < 0 || n < loop_n) begin
			return n;
		end
		return mark_addr + 1 + n - loop_n;
	endfunction

	task automatic wait_state(input logic ready, input logic motor, input string what);
		int t;
		t = 0;
		while (tape_ready_o !== ready || motor_o !== motor) begin
			step();
			t++;
			if (t > 20) fail_timeout(what);
		end
	endtask

	task automatic wait_restart(input logic level, input string what);
		int t;
		t = 0;
		while (player_restart_o !== level) begin
			step();
			t++;
			if (t > 20) fail_timeout(what);
		end
	endtask

	task automatic request();
		int t;
		t = 0;
		tzx_req_i = ~tzx_req_i;
		issued++;
		while (tzx_ack_o !== tzx_req_i) begin
			step();
			t++;
			if (t > 10) fail_timeout("the request acknowledge");
		end
		repeat ($urandom_range(3, 0)) step();
	endtask

	task automatic press_key(input logic [8:0] code, input logic pressed);
		ps2_key_i.code    = code;
		ps2_key_i.pressed = pressed;
		ps2_key_i.strobe  = ~ps2_key_i.strobe;
		step();
	endtask

	task automatic pulse_event(input tzx_event_t evt);
		tzx_evt_i = evt;
		step();
		tzx_evt_i = '0;
	endtask

	// Download counts the address up, its last value is the tape length
	task automatic load_tape(input int n);
		int i;
		download_i = 1'b1;
		for (i = 0; i <= n; i++) begin
			dl_addr_i = ADDR_W'(i);
			step();
		end
		download_i = 1'b0;
		wait_state(1'b1, 1'b1, "tape ready after download");
		check_value(tape_addr_o, 0, "tape_addr_o after download");
		check_value(player_restart_o, 0, "player_restart_o after download");
		issued  = 0;
		seen    = 0;
		loop_at = -1;
	endtask

	// Steady means no change over a full turn of the LED counter
	task automatic led_steady(input logic level);
		int run;
		int t;
		run = 0;
		t   = 0;
		while (run <= (1 << LED_BITS)) begin
			step();
			run = (led_o === level) ? run + 1 : 0;
			t++;
			if (t > 3 * (1 << LED_BITS)) fail_timeout("a steady LED level");
		end
	endtask

	task automatic check_ce(input int speed, input logic stall, input int exp);
		int n;
		cpu_speed_i = cpu_speed_t'(speed);
		mem_wait_i  = stall;
		repeat (64) step();
		n = 0;
		repeat (128) begin
			step();
			if (tape_ce_o) n++;
		end
		check_value(n, exp, "tape_ce_o pulses in 128 cycles");
	endtask

	// Every acknowledge change carries one byte address
	always @(negedge clk_sys) begin
		if (!RESET && tzx_ack_o !== ack_seen) begin
			check_value(tape_addr_o, ref_addr(seen, loop_at, mark), "tape_addr_o");
			seen++;
		end
		ack_seen = tzx_ack_o;
	end

	initial begin
		void'($urandom(32'ha866_c7aa));
		RESET       = 1'b1;
		ps2_key_i   = '0;
		download_i  = 1'b0;
		dl_addr_i   = '0;
		tzx_req_i   = 1'b0;
		tzx_evt_i   = '0;
		cpu_speed_i = SPEED_3M5;
		mem_wait_i  = 1'b0;
		repeat (8) step();
		RESET = 1'b0;
		step();
		check_value(tape_ready_o, 0, "tape_ready_o after reset");
		check_value(motor_o, 0, "motor_o after reset");
		check_value(tape_addr_o, 0, "tape_addr_o after reset");
		check_value(player_restart_o, 1, "player_restart_o after reset");

		// ========================================
		// Random tape with one loop block
		// ========================================
		len = $urandom_range(60, 24);
		load_tape(len);
		repeat ($urandom_range(8, 3)) request();
		mark = issued;
		pulse_event(EV_LOOP);
		repeat ($urandom_range(5, 2)) request();
		pulse_event(EV_NEXT);
		loop_at = issued;
		check_value(tape_addr_o, mark, "tape_addr_o on loop_next");
		while (ref_addr(issued, loop_at, mark) < len) request();
		check_value(tape_ready_o, 1, "tape_ready_o before the last byte");
		request();
		wait_state(1'b0, 1'b0, "end of tape");
		check_value(player_restart_o, 1, "player_restart_o at end of tape");
		led_steady(1'b0);

		// ========================================
		// Keys and player stop
		// ========================================
		load_tape(200);
		repeat (3) request();
		press_key(KEY_F5, 1'b1);
		wait_state(1'b1, 1'b0, "pause on F5");
		led_steady(1'b1);
		press_key(KEY_F5, 1'b1);
		wait_state(1'b1, 1'b1, "play on F5");
		press_key(KEY_F6, 1'b1);
		wait_restart(1'b1, "player restart on F6");
		wait_state(1'b1, 1'b0, "pause on F6");
		wait_restart(1'b0, "end of the F6 restart");
		check_value(tape_addr_o, 0, "tape_addr_o after F6");
		issued = 0;
		seen   = 0;
		repeat (2) request();
		press_key(KEY_F5, 1'b1);
		wait_state(1'b1, 1'b1, "play after restart");
		pulse_event(EV_STOP);
		wait_state(1'b1, 1'b0, "pause on stop event");
		press_key(KEY_F7, 1'b1);
		wait_state(1'b0, 1'b0, "eject on F7");
		check_value(player_restart_o, 1, "player_restart_o after F7");

		// Enable rate per speed, fast speeds stall on memory wait
		for (s = 0; s < 4; s++) begin
			check_ce(s, 1'b0, 4 << s);
		end
		check_ce(1, 1'b1, 8);
		check_ce(2, 1'b1, 0);
		check_ce(3, 1'b1, 0);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
